// ==== list.f ====
rtl/cpu_defs_pkg.sv
rtl/rv_isa_pkg.sv
rtl/branch_predictor.sv
rtl/icache_fetcher.sv
rtl/mem_ctrl.sv
rtl/fetch_unit.sv
sim/apb_mem_model.sv
sim/tb_fetch_unit.sv

// ==== rtl/branch_predictor.sv ====
module branch_predictor #(
    parameter int BHT_ENTRIES = 64
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [cpu_defs_pkg::XLEN-1:0] query_pc,
    input  logic [cpu_defs_pkg::XLEN-1:0] query_inst,
    output logic                          pred_taken,
    output logic [cpu_defs_pkg::XLEN-1:0] pred_offset,

    input  logic                          upd_valid,
    input  logic [cpu_defs_pkg::XLEN-1:0] upd_pc,
    input  logic                          upd_taken
);

    localparam int XLEN     = cpu_defs_pkg::XLEN;
    localparam int OFF      = cpu_defs_pkg::OFFSET_BITS;
    localparam int IDX_BITS = $clog2(BHT_ENTRIES);
    localparam int SIGN     = rv_isa_pkg::IMM_SIGN_BIT;

    logic [1:0] bht [BHT_ENTRIES];

    rv_isa_pkg::opcode_t opcode;
    logic [XLEN-1:0]     j_imm;
    logic [XLEN-1:0]     b_imm;
    logic [IDX_BITS-1:0] query_idx;
    logic [IDX_BITS-1:0] upd_idx;
    logic [1:0]          counter;

    assign opcode = rv_isa_pkg::opcode_t'(
        query_inst[rv_isa_pkg::OPCODE_MSB:rv_isa_pkg::OPCODE_LSB]);

    // J-type: imm[20|10:1|11|19:12]
    assign j_imm = {{12{query_inst[SIGN]}}, query_inst[19:12], query_inst[20],
                    query_inst[30:21], 1'b0};

    // B-type: imm[12|10:5] ... imm[4:1|11]
    assign b_imm = {{20{query_inst[SIGN]}}, query_inst[7], query_inst[30:25],
                    query_inst[11:8], 1'b0};

    assign query_idx = query_pc[IDX_BITS+OFF-1:OFF];
    assign upd_idx   = upd_pc[IDX_BITS+OFF-1:OFF];
    assign counter   = bht[query_idx];

    always_comb begin
        pred_taken  = 1'b0;
        pred_offset = cpu_defs_pkg::INST_BYTES;
        case (opcode)
            rv_isa_pkg::op_jal: begin
                pred_taken  = 1'b1;
                pred_offset = j_imm;
            end
            rv_isa_pkg::op_branch: begin
                // taken when counter is 2 or 3
                if (counter[1]) begin
                    pred_taken  = 1'b1;
                    pred_offset = b_imm;
                end
            end
            default: begin
                pred_taken  = 1'b0;
                pred_offset = cpu_defs_pkg::INST_BYTES;
            end
        endcase
    end

    // saturating two-bit counters, weakly not taken after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (upd_valid) begin
            if (upd_taken && bht[upd_idx] != 2'b11) begin
                bht[upd_idx] <= bht[upd_idx] + 2'b01;
            end else if (!upd_taken && bht[upd_idx] != 2'b00) begin
                bht[upd_idx] <= bht[upd_idx] - 2'b01;
            end
        end
    end

endmodule

// ==== rtl/cpu_defs_pkg.sv ====
package cpu_defs_pkg;

    // address and instruction width
    parameter int XLEN = 32;

    // byte offset bits of a word address, skipped by every index
    parameter int OFFSET_BITS = 2;

    // fetch restarts here after reset
    parameter logic [XLEN-1:0] RESET_PC = '0;

    // pc step for a not-taken instruction
    parameter logic [XLEN-1:0] INST_BYTES = XLEN'(4);

    // refill state of the fetcher
    // fetch_idle sends the next refill request,
    // fetch_wait waits for the memory controller to answer
    typedef enum logic {
        fetch_idle,
        fetch_wait
    } fetch_state_t;

endpackage

// ==== rtl/fetch_unit.sv ====
module fetch_unit #(
    parameter int ICACHE_LINES = 256,
    parameter int BHT_ENTRIES  = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          full,

    // from the reorder buffer
    input  logic                          rollback,
    input  logic [cpu_defs_pkg::XLEN-1:0] rollback_pc,
    input  logic                          upd_valid,
    input  logic [cpu_defs_pkg::XLEN-1:0] upd_pc,
    input  logic                          upd_taken,

    // to the dispatcher
    output logic                          inst_ok,
    output logic [cpu_defs_pkg::XLEN-1:0] inst,
    output logic [cpu_defs_pkg::XLEN-1:0] inst_pc,
    output logic                          pred_taken_out,
    output logic [cpu_defs_pkg::XLEN-1:0] fall_pc,

    // APB to instruction memory
    output logic                          psel,
    output logic                          penable,
    output logic                          pwrite,
    output logic [cpu_defs_pkg::XLEN-1:0] paddr,
    input  logic [cpu_defs_pkg::XLEN-1:0] prdata,
    input  logic                          pready
);

    logic [cpu_defs_pkg::XLEN-1:0] query_pc;
    logic [cpu_defs_pkg::XLEN-1:0] query_inst;
    logic                          pred_taken;
    logic [cpu_defs_pkg::XLEN-1:0] pred_offset;

    logic                          mem_req;
    logic [cpu_defs_pkg::XLEN-1:0] mem_addr;
    logic                          mem_drop;
    logic                          mem_ok;
    logic [cpu_defs_pkg::XLEN-1:0] mem_data;

    icache_fetcher #(
        .ICACHE_LINES(ICACHE_LINES)
    ) fetcher_inst (
        .clk(clk), .rst(rst), .rdy(rdy), .full(full),
        .rollback(rollback), .rollback_pc(rollback_pc),
        .query_pc(query_pc), .query_inst(query_inst),
        .pred_taken(pred_taken), .pred_offset(pred_offset),
        .inst_ok(inst_ok), .inst(inst), .inst_pc(inst_pc),
        .pred_taken_out(pred_taken_out), .fall_pc(fall_pc),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_drop(mem_drop),
        .mem_ok(mem_ok), .mem_data(mem_data)
    );

    branch_predictor #(
        .BHT_ENTRIES(BHT_ENTRIES)
    ) predictor_inst (
        .clk(clk), .rst(rst),
        .query_pc(query_pc), .query_inst(query_inst),
        .pred_taken(pred_taken), .pred_offset(pred_offset),
        .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_taken(upd_taken)
    );

    mem_ctrl mem_ctrl_inst (
        .clk(clk), .rst(rst), .rdy(rdy),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_drop(mem_drop),
        .mem_ok(mem_ok), .mem_data(mem_data),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .prdata(prdata), .pready(pready)
    );

endmodule

// ==== rtl/icache_fetcher.sv ====
module icache_fetcher #(
    parameter int ICACHE_LINES = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          full,
    input  logic                          rollback,
    input  logic [cpu_defs_pkg::XLEN-1:0] rollback_pc,

    // predictor lookup
    output logic [cpu_defs_pkg::XLEN-1:0] query_pc,
    output logic [cpu_defs_pkg::XLEN-1:0] query_inst,
    input  logic                          pred_taken,
    input  logic [cpu_defs_pkg::XLEN-1:0] pred_offset,

    // to the dispatcher
    output logic                          inst_ok,
    output logic [cpu_defs_pkg::XLEN-1:0] inst,
    output logic [cpu_defs_pkg::XLEN-1:0] inst_pc,
    output logic                          pred_taken_out,
    output logic [cpu_defs_pkg::XLEN-1:0] fall_pc,

    // refill path to the memory controller
    output logic                          mem_req,
    output logic [cpu_defs_pkg::XLEN-1:0] mem_addr,
    output logic                          mem_drop,
    input  logic                          mem_ok,
    input  logic [cpu_defs_pkg::XLEN-1:0] mem_data
);

    localparam int XLEN     = cpu_defs_pkg::XLEN;
    localparam int OFF      = cpu_defs_pkg::OFFSET_BITS;
    localparam int IDX_BITS = $clog2(ICACHE_LINES);
    localparam int TAG_BITS = XLEN - IDX_BITS - OFF;

    logic [XLEN-1:0]             pc;
    logic [XLEN-1:0]             mem_pc;
    cpu_defs_pkg::fetch_state_t  state;

    // one word per line
    logic [ICACHE_LINES-1:0]     valid;
    logic [TAG_BITS-1:0]         tag_mem  [ICACHE_LINES];
    logic [XLEN-1:0]             data_mem [ICACHE_LINES];

    logic [IDX_BITS-1:0]         pc_idx;
    logic [TAG_BITS-1:0]         pc_tag;
    logic [IDX_BITS-1:0]         fill_idx;
    logic [TAG_BITS-1:0]         fill_tag;
    logic                        hit;
    logic                        run;
    logic                        fill_we;

    assign pc_idx   = pc[IDX_BITS+OFF-1:OFF];
    assign pc_tag   = pc[XLEN-1:IDX_BITS+OFF];
    assign fill_idx = mem_pc[IDX_BITS+OFF-1:OFF];
    assign fill_tag = mem_pc[XLEN-1:IDX_BITS+OFF];

    assign hit = valid[pc_idx] && (tag_mem[pc_idx] == pc_tag);

    assign query_pc   = pc;
    assign query_inst = hit ? data_mem[pc_idx] : '0;

    // normal operation: not stalled and not redirected
    assign run     = rdy && !rollback;
    assign fill_we = run && (state == cpu_defs_pkg::fetch_wait) && mem_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= cpu_defs_pkg::RESET_PC;
            mem_pc   <= cpu_defs_pkg::RESET_PC;
            state    <= cpu_defs_pkg::fetch_idle;
            valid    <= '0;
            inst_ok  <= 1'b0;
            mem_req  <= 1'b0;
            mem_drop <= 1'b0;
        end else if (!rdy) begin
            // whole unit frozen
        end else if (rollback) begin
            pc       <= rollback_pc;
            mem_pc   <= rollback_pc;
            state    <= cpu_defs_pkg::fetch_idle;
            inst_ok  <= 1'b0;
            mem_req  <= 1'b0;
            mem_drop <= 1'b1;
        end else begin
            // issue on hit unless the dispatcher is full
            inst_ok <= hit && !full;
            if (hit && !full) begin
                pc <= pc + pred_offset;
            end

            mem_req  <= 1'b0;
            mem_drop <= 1'b0;

            if (state == cpu_defs_pkg::fetch_idle) begin
                mem_req <= 1'b1;
                state   <= cpu_defs_pkg::fetch_wait;
            end else if (mem_ok) begin
                // prefetch ahead while fetch sits on the refilled word,
                // otherwise chase the current pc
                mem_pc          <= (mem_pc == pc) ? mem_pc + cpu_defs_pkg::INST_BYTES : pc;
                state           <= cpu_defs_pkg::fetch_idle;
                valid[fill_idx] <= 1'b1;
            end
        end
    end

    // issue payload and refill address
    always_ff @(posedge clk) begin
        if (run && hit && !full) begin
            inst           <= query_inst;
            inst_pc        <= pc;
            pred_taken_out <= pred_taken;
            fall_pc        <= pc + cpu_defs_pkg::INST_BYTES;
        end
        if (run && state == cpu_defs_pkg::fetch_idle) begin
            mem_addr <= mem_pc;
        end
    end

    // line fill
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= mem_data;
        end
    end

endmodule

// ==== rtl/mem_ctrl.sv ====
module mem_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,

    // fetcher side
    input  logic                          mem_req,
    input  logic [cpu_defs_pkg::XLEN-1:0] mem_addr,
    input  logic                          mem_drop,
    output logic                          mem_ok,
    output logic [cpu_defs_pkg::XLEN-1:0] mem_data,

    // APB requester
    output logic                          psel,
    output logic                          penable,
    output logic                          pwrite,
    output logic [cpu_defs_pkg::XLEN-1:0] paddr,
    input  logic [cpu_defs_pkg::XLEN-1:0] prdata,
    input  logic                          pready
);

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

    apb_state_t                   state;
    logic                         dropped;
    logic                         pend;
    logic [cpu_defs_pkg::XLEN-1:0] pend_addr;
    logic                         req_now;
    logic                         drop_now;
    logic                         start;

    // fetcher pulses only count on cycles where the unit runs
    assign req_now  = rdy && mem_req;
    assign drop_now = rdy && mem_drop;
    assign start    = (state == apb_idle) && (req_now || (rdy && pend && !drop_now));

    // read-only master
    assign pwrite = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= apb_idle;
            psel    <= 1'b0;
            penable <= 1'b0;
            mem_ok  <= 1'b0;
            dropped <= 1'b0;
            pend    <= 1'b0;
        end else begin
            // fetcher consumes ok on an rdy cycle
            if (rdy) begin
                mem_ok <= 1'b0;
            end

            if (drop_now) begin
                pend <= 1'b0;
                if (state != apb_idle) begin
                    dropped <= 1'b1;
                end
            end

            // request while a dropped transfer drains
            if (req_now && state != apb_idle) begin
                pend <= 1'b1;
            end

            case (state)
                apb_idle: begin
                    if (start) begin
                        psel    <= 1'b1;
                        pend    <= 1'b0;
                        dropped <= 1'b0;
                        state   <= apb_setup;
                    end
                end
                apb_setup: begin
                    penable <= 1'b1;
                    state   <= apb_access;
                end
                apb_access: begin
                    if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        mem_ok  <= !(dropped || drop_now);
                        state   <= apb_idle;
                    end
                end
                default: state <= apb_idle;
            endcase
        end
    end

    // address and read data
    always_ff @(posedge clk) begin
        if (start) begin
            paddr <= req_now ? mem_addr : pend_addr;
        end
        if (req_now && state != apb_idle) begin
            pend_addr <= mem_addr;
        end
        if (state == apb_access && pready) begin
            mem_data <= prdata;
        end
    end

endmodule

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // opcode field position in a 32-bit instruction
    parameter int OPCODE_LSB = 0;
    parameter int OPCODE_MSB = 6;

    // sign bit of every immediate format
    parameter int IMM_SIGN_BIT = 31;

    // RV32I major opcodes
    // only jal and branch matter to the predictor
    typedef enum logic [OPCODE_MSB:OPCODE_LSB] {
        op_jal          = 7'b1101111,
        op_branch       = 7'b1100011,
        op_other_lui    = 7'b0110111,
        op_other_auipc  = 7'b0010111,
        op_other_jalr   = 7'b1100111,
        op_other_load   = 7'b0000011,
        op_other_store  = 7'b0100011,
        op_other_imm    = 7'b0010011,
        op_other_reg    = 7'b0110011,
        op_other_fence  = 7'b0001111,
        op_other_system = 7'b1110011
    } opcode_t;

endpackage

// ==== sim/apb_mem_model.sv ====
module apb_mem_model #(
    parameter int WORDS = 64
) (
    input  logic        clk,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        write_seen
);

    localparam int IDX_BITS = $clog2(WORDS);

    // program image that the testbench fills before reset ends
    logic [31:0] mem [WORDS];
    int          waits;

    // past the program an addi whose upper bits fold in the whole address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if ((addr >> (IDX_BITS + 2)) == 0) begin
            return mem[addr[IDX_BITS+1:2]];
        end else begin
            return {addr[31:7] ^ {18'b0, addr[6:0]}, 7'b0010011};
        end
    endfunction

    initial begin
        prdata     = '0;
        pready     = 1'b0;
        write_seen = 1'b0;
        waits      = 0;
    end

    // sticky flag for any write request
    always @(posedge clk) begin
        if (psel && pwrite) begin
            write_seen <= 1'b1;
        end
    end

    // 0 to 3 wait states chosen in the setup phase
    always @(negedge clk) begin
        pready = 1'b0;
        if (psel && !penable) begin
            waits = $urandom % 4;
        end else if (psel && penable) begin
            if (waits == 0) begin
                pready = 1'b1;
                prdata = read_word(paddr);
            end else begin
                waits--;
            end
        end
    end

endmodule

// ==== sim/tb_fetch_unit.sv ====
module tb_fetch_unit;

    localparam int PROG_WORDS  = 64;
    localparam int BHT_ENTRIES = 64;
    localparam int SEED        = 20038;
    localparam int TIMEOUT     = 200;
    localparam int REUSE_LEN   = 12;
    localparam int BRANCH_WORD = 20;

    logic        clk, rst, rdy, full;
    logic        rollback, upd_valid, upd_taken;
    logic [31:0] rollback_pc, upd_pc;
    logic        inst_ok, pred_taken_out;
    logic [31:0] inst, inst_pc, fall_pc;
    logic        psel, penable, pwrite, pready, write_seen;
    logic [31:0] paddr, prdata;

    // program image and its generator view
    // kind 1 is jal and kind 2 a branch
    logic [31:0] prog_word [PROG_WORDS];
    int          prog_kind [PROG_WORDS];
    int          prog_off  [PROG_WORDS];
    logic [1:0]  model_bht [BHT_ENTRIES];
    logic [31:0] model_pc;
    logic [31:0] target;
    logic        issued;
    string       test_name;
    int          seed_val;

    fetch_unit #(.BHT_ENTRIES(BHT_ENTRIES)) fetch_unit_inst (.*);

    apb_mem_model #(.WORDS(PROG_WORDS)) mem_model_inst (.*);

    function automatic logic [31:0] encode_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic build_program();
        logic [6:0] plain_ops [5];
        int         roll;
        int         dest;
        plain_ops = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b0110111};
        for (int i = 0; i < PROG_WORDS; i++) begin
            roll = $urandom % 8;
            dest = i + int'($urandom % 11) - 4;
            if (dest < 0 || dest == i) begin
                dest = i + 1;
            end
            if (dest >= PROG_WORDS) begin
                dest = i - 1;
            end
            prog_off[i]  = (dest - i) * 4;
            prog_kind[i] = (roll == 0) ? 1 : (roll < 3) ? 2 : 0;
        end
        prog_kind[BRANCH_WORD]  = 2;
        prog_off[BRANCH_WORD]   = 12;
        // last word jumps home so fetch never leaves the program
        prog_kind[PROG_WORDS-1] = 1;
        prog_off[PROG_WORDS-1]  = -4 * (PROG_WORDS - 1);
        for (int i = 0; i < PROG_WORDS; i++) begin
            case (prog_kind[i])
                1: prog_word[i] = encode_jal(prog_off[i]);
                2: prog_word[i] = encode_branch(prog_off[i]);
                default: prog_word[i] = {25'($urandom), plain_ops[$urandom % 5]};
            endcase
            mem_model_inst.mem[i] = prog_word[i];
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("MISMATCH %s %s expected %h actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic update_model_counter(input logic [31:0] pc, input logic taken);
        int e;
        e = (pc / 4) % BHT_ENTRIES;
        if (taken && model_bht[e] != 2'd3) begin
            model_bht[e] = model_bht[e] + 2'd1;
        end else if (!taken && model_bht[e] != 2'd0) begin
            model_bht[e] = model_bht[e] - 2'd1;
        end
    endtask

    // compare with the word at the model pc and step by the predicted direction
    task automatic check_issue();
        int   w;
        logic taken;
        w     = (model_pc / 4) % PROG_WORDS;
        taken = prog_kind[w] == 1 ||
                (prog_kind[w] == 2 && model_bht[(model_pc / 4) % BHT_ENTRIES] >= 2'd2);
        check("inst_pc", model_pc, inst_pc);
        check("inst", prog_word[w], inst);
        check("pred_taken", taken, pred_taken_out);
        check("fall_pc", model_pc + 4, fall_pc);
        model_pc = taken ? model_pc + prog_off[w] : model_pc + 4;
    endtask

    // inputs still hold what the last edge saw when outputs are read here
    task automatic step();
        @(posedge clk);
        @(negedge clk);
        issued = rdy && inst_ok;
        if (write_seen) begin
            fail_run("the fetch unit started an APB write");
        end
        if (rdy && (full || rollback)) begin
            check("no_issue", 0, inst_ok);
        end
        if (issued) begin
            check_issue();
        end
        if (upd_valid) begin
            update_model_counter(upd_pc, upd_taken);
        end
        if (rdy && rollback) begin
            model_pc = rollback_pc;
        end
    endtask

    task automatic wait_issue();
        int cycles;
        cycles = 0;
        step();
        while (!issued) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("fetch stalled with no instruction issued before the timeout");
            end
            step();
        end
    endtask

    task automatic train(input logic [31:0] pc, input logic taken);
        upd_valid = 1'b1;
        upd_pc    = pc;
        upd_taken = taken;
        step();
        upd_valid = 1'b0;
    endtask

    task automatic redirect(input logic [31:0] pc);
        rollback    = 1'b1;
        rollback_pc = pc;
        step();
        rollback    = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        seed_val    = $urandom(SEED);
        rst         = 1'b1;
        rdy         = 1'b1;
        full        = 1'b0;
        rollback    = 1'b0;
        rollback_pc = '0;
        upd_valid   = 1'b0;
        upd_pc      = '0;
        upd_taken   = 1'b0;
        model_pc    = '0;
        test_name   = "reset";
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            model_bht[i] = 2'd1;
        end
        build_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        check("inst_ok", 0, inst_ok);
        check("psel", 0, psel);
        check("penable", 0, penable);
        rst = 1'b0;

        test_name = "sequential";
        repeat (150) wait_issue();

        // two taken updates flip a weakly not taken counter and two more flip it back
        test_name = "prediction";
        target = BRANCH_WORD * 4;
        train(target, 1'b1);
        train(target, 1'b1);
        redirect(target);
        wait_issue();
        check("trained_taken", 1, pred_taken_out);
        train(target, 1'b0);
        train(target, 1'b0);
        redirect(target);
        wait_issue();
        check("trained_not_taken", 0, pred_taken_out);

        test_name = "back_pressure";
        repeat (40) begin
            repeat ($urandom % 8) step();
            full = 1'b1;
            repeat (1 + $urandom % 5) step();
            full = 1'b0;
        end

        test_name = "rollback";
        repeat (40) begin
            repeat ($urandom % 20) step();
            train(($urandom % PROG_WORDS) * 4, 1'($urandom));
            target = ($urandom % PROG_WORDS) * 4;
            redirect(target);
            wait_issue();
        end

        test_name = "rdy_stall";
        repeat (40) begin
            repeat ($urandom % 10) step();
            rdy = 1'b0;
            repeat (1 + $urandom % 6) step();
            rdy = 1'b1;
            wait_issue();
        end

        // second pass over a cached stretch issues every cycle
        test_name = "cache_reuse";
        repeat (8) begin
            target = ($urandom % PROG_WORDS) * 4;
            redirect(target);
            repeat (REUSE_LEN) wait_issue();
            redirect(target);
            repeat (REUSE_LEN) begin
                step();
                check("back_to_back_issue", 1, issued);
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule
